// File: hw/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

  // cache geometry.
  localparam int L1I_SETS = 4;
  localparam int L1I_WORDS = 2;
  localparam int IDX_W = $clog2(L1I_SETS);
  localparam int OFF_W = $clog2(L1I_WORDS);
  localparam int TAG_W = 27;

  // reset values.
  localparam logic [31:0] PC_RESET = 32'h8000_0000;
  localparam logic [31:0] CFG_BASE_RESET = 32'h8000_0000;
  localparam logic [31:0] CFG_LIMIT_RESET = 32'h8000_00FF;

  // opcodes that end sequential fetch.
  localparam logic [6:0] OP_JAL = 7'b110_1111;
  localparam logic [6:0] OP_JALR = 7'b110_0111;
  localparam logic [6:0] OP_BRANCH = 7'b110_0011;
  localparam logic [6:0] OP_SYSTEM = 7'b111_0011;
  localparam logic [31:0] INST_FENCE_I = 32'h0000_100F;

  // bit 0 of the ctrl register is the cache enable.
  localparam logic [1:0] CFG_ADDR_CTRL = 2'd0;
  localparam logic [1:0] CFG_ADDR_BASE = 2'd1;
  localparam logic [1:0] CFG_ADDR_LIMIT = 2'd2;

  // fill machine states of the cache.
  localparam logic [1:0] FILL_IDLE = 2'd0;
  localparam logic [1:0] FILL_EVEN = 2'd1;
  localparam logic [1:0] FILL_ODD = 2'd2;
  localparam logic [1:0] FILL_BYPASS = 2'd3;

  // the fetch address seen as a plain word or split into cache fields.
  typedef union packed {
    logic [31:0] word;
    struct packed {
      logic [TAG_W-1:0] tag;
      logic [IDX_W-1:0] index;
      logic [OFF_W-1:0] offset;
      logic [1:0] bsel;
    } f;
  } fetch_addr_u;

endpackage

`default_nettype wire

// File: hw/l1i_lookup_if.sv
`timescale 1ns/1ns
`default_nettype none

interface l1i_lookup_if
  import fetch_pkg::*;
();

  fetch_addr_u pc;
  logic req;
  logic flush;
  logic [31:0] inst;
  logic hit;

  // inst is only meaningful while both req and hit are high.
  modport ctrl (output pc, output req, output flush, input inst, input hit);

  modport cache (input pc, input req, input flush, output inst, output hit);

endinterface

`default_nettype wire

// File: hw/fetch_cfg_regs.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_cfg_regs
  import fetch_pkg::*;
(
  input  wire         clk,
  input  wire         rst,
  input  wire         cfg_we_i,
  input  wire  [1:0]  cfg_addr_i,
  input  wire  [31:0] cfg_wdata_i,
  output logic        cache_en_o,
  output logic [31:0] win_base_o,
  output logic [31:0] win_limit_o
);

  logic        cache_en;
  logic [31:0] win_base;
  logic [31:0] win_limit;

  always_ff @(posedge clk) begin
    if (rst) begin
      cache_en <= 1'b1;
      win_base <= CFG_BASE_RESET;
      win_limit <= CFG_LIMIT_RESET;
    end else if (cfg_we_i) begin
      // unmapped addresses fall through.
      case (cfg_addr_i)
        CFG_ADDR_CTRL: begin
          cache_en <= cfg_wdata_i[0];
        end
        CFG_ADDR_BASE: begin
          win_base <= cfg_wdata_i;
        end
        CFG_ADDR_LIMIT: begin
          win_limit <= cfg_wdata_i;
        end
        default: begin
        end
      endcase
    end
  end

  assign cache_en_o = cache_en;
  assign win_base_o = win_base;
  assign win_limit_o = win_limit;

endmodule

`default_nettype wire

// File: hw/l1i_cache.sv
`timescale 1ns/1ns
`default_nettype none

module l1i_cache
  import fetch_pkg::*;
(
  input  wire               clk,
  input  wire               rst,
  l1i_lookup_if.cache       lookup,
  input  wire               cache_en_i,
  input  wire        [31:0] win_base_i,
  input  wire        [31:0] win_limit_i,
  output logic       [31:0] mem_araddr_o,
  output logic              mem_arvalid_o,
  input  wire        [31:0] mem_rdata_i,
  input  wire               mem_rvalid_i
);

  fetch_addr_u         pc;
  logic [1:0]          state;
  logic [L1I_SETS-1:0] line_valid;
  logic [TAG_W-1:0]    tag_mem [L1I_SETS];
  logic [31:0]         data_mem [L1I_SETS][L1I_WORDS];

  logic cacheable;
  logic array_hit;
  logic bypass_hit;
  logic miss;

  assign pc = lookup.pc;

  // caching needs the enable bit and a pc inside the window.
  assign cacheable = cache_en_i && (pc.word >= win_base_i) && (pc.word <= win_limit_i);

  // a stored line counts only while its address is still cacheable.
  assign array_hit = cacheable && line_valid[pc.f.index] &&
                     (tag_mem[pc.f.index] == pc.f.tag);

  // uncached data is forwarded in the cycle it returns.
  assign bypass_hit = (state == FILL_BYPASS) && mem_rvalid_i;

  assign lookup.hit = array_hit || bypass_hit;
  assign lookup.inst = bypass_hit ? mem_rdata_i : data_mem[pc.f.index][pc.f.offset];

  assign miss = lookup.req && !lookup.hit;

  always_comb begin
    case (state)
      FILL_EVEN: begin
        mem_araddr_o = {pc.word[31:3], 3'b000};
      end
      FILL_ODD: begin
        mem_araddr_o = {pc.word[31:3], 3'b100};
      end
      default: begin
        mem_araddr_o = {pc.word[31:2], 2'b00};
      end
    endcase
  end

  assign mem_arvalid_o = (state != FILL_IDLE);

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= FILL_IDLE;
      line_valid <= '0;
    end else begin
      case (state)
        FILL_IDLE: begin
          if (miss) begin
            state <= cacheable ? FILL_EVEN : FILL_BYPASS;
          end
        end
        FILL_EVEN: begin
          if (mem_rvalid_i) begin
            state <= FILL_ODD;
          end
        end
        FILL_ODD: begin
          if (mem_rvalid_i) begin
            state <= FILL_IDLE;
            line_valid[pc.f.index] <= 1'b1;
          end
        end
        FILL_BYPASS: begin
          if (mem_rvalid_i) begin
            state <= FILL_IDLE;
          end
        end
        default: begin
          state <= FILL_IDLE;
        end
      endcase
      // fence.i wins over a line that completes in the same cycle.
      if (lookup.flush) begin
        line_valid <= '0;
      end
    end
  end

  // tag and data arrays.
  always_ff @(posedge clk) begin
    if (mem_rvalid_i) begin
      if (state == FILL_EVEN) begin
        data_mem[pc.f.index][0] <= mem_rdata_i;
      end
      if (state == FILL_ODD) begin
        data_mem[pc.f.index][1] <= mem_rdata_i;
        tag_mem[pc.f.index] <= pc.f.tag;
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/ifu_pc_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module ifu_pc_ctrl
  import fetch_pkg::*;
(
  input  wire         clk,
  input  wire         rst,
  l1i_lookup_if.ctrl  lookup,
  output logic [31:0] inst_o,
  output logic [31:0] pc_o,
  output logic        valid_o,
  input  wire         ready_i,
  input  wire         redirect_i,
  input  wire  [31:0] npc_i
);

  fetch_addr_u pc;
  fetch_addr_u npc_aligned;
  logic        stall;
  logic        held_valid;
  logic [31:0] held_inst;
  logic [31:0] cur_inst;
  logic [6:0]  opcode;
  logic        is_cf;
  logic        is_fence_i;
  logic        xfer;

  // no lookup while waiting for a redirect or holding a word.
  assign lookup.req = !stall && !held_valid;
  assign lookup.pc = pc;

  assign cur_inst = held_valid ? held_inst : lookup.inst;
  assign valid_o = held_valid || (lookup.req && lookup.hit);
  assign xfer = valid_o && ready_i;

  assign opcode = cur_inst[6:0];
  assign is_cf = (opcode == OP_JAL) || (opcode == OP_JALR) ||
                 (opcode == OP_BRANCH) || (opcode == OP_SYSTEM);
  assign is_fence_i = (cur_inst == INST_FENCE_I);

  assign lookup.flush = xfer && is_fence_i;

  assign inst_o = cur_inst;
  assign pc_o = pc.word;

  // redirect targets are forced onto a word boundary.
  always_comb begin
    npc_aligned.word = npc_i;
    npc_aligned.f.bsel = 2'b00;
  end

  // bypass data lasts one cycle so a word offered while decode is busy is kept.
  always_ff @(posedge clk) begin
    if (lookup.req && lookup.hit && !ready_i) begin
      held_inst <= lookup.inst;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc.word <= PC_RESET;
      stall <= 1'b0;
      held_valid <= 1'b0;
    end else begin
      if (xfer) begin
        held_valid <= 1'b0;
        if (is_cf) begin
          stall <= 1'b1;
        end else begin
          pc.word <= pc.word + 32'd4;
        end
      end else if (lookup.req && lookup.hit) begin
        held_valid <= 1'b1;
      end
      // Redirects outside a stall are dropped.
      if (stall && redirect_i) begin
        stall <= 1'b0;
        pc <= npc_aligned;
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/fetch_top.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_top (
  input  wire         clk,
  input  wire         rst,
  // decode side.
  output logic [31:0] inst_o,
  output logic [31:0] pc_o,
  output logic        valid_o,
  input  wire         ready_i,
  input  wire         redirect_i,
  input  wire  [31:0] npc_i,
  // memory read bus.
  output logic [31:0] mem_araddr_o,
  output logic        mem_arvalid_o,
  input  wire  [31:0] mem_rdata_i,
  input  wire         mem_rvalid_i,
  // configuration writes.
  input  wire         cfg_we_i,
  input  wire  [1:0]  cfg_addr_i,
  input  wire  [31:0] cfg_wdata_i
);

  logic        cache_en;
  logic [31:0] win_base;
  logic [31:0] win_limit;

  l1i_lookup_if lookup_bus ();

  fetch_cfg_regs u_cfg (
    .clk         (clk),
    .rst         (rst),
    .cfg_we_i    (cfg_we_i),
    .cfg_addr_i  (cfg_addr_i),
    .cfg_wdata_i (cfg_wdata_i),
    .cache_en_o  (cache_en),
    .win_base_o  (win_base),
    .win_limit_o (win_limit)
  );

  l1i_cache u_cache (
    .clk           (clk),
    .rst           (rst),
    .lookup        (lookup_bus.cache),
    .cache_en_i    (cache_en),
    .win_base_i    (win_base),
    .win_limit_i   (win_limit),
    .mem_araddr_o  (mem_araddr_o),
    .mem_arvalid_o (mem_arvalid_o),
    .mem_rdata_i   (mem_rdata_i),
    .mem_rvalid_i  (mem_rvalid_i)
  );

  ifu_pc_ctrl u_pc_ctrl (
    .clk        (clk),
    .rst        (rst),
    .lookup     (lookup_bus.ctrl),
    .inst_o     (inst_o),
    .pc_o       (pc_o),
    .valid_o    (valid_o),
    .ready_i    (ready_i),
    .redirect_i (redirect_i),
    .npc_i      (npc_i)
  );

endmodule

`default_nettype wire

// File: sim/tb_fetch_checks.svh
`ifndef TB_FETCH_CHECKS_SVH
`define TB_FETCH_CHECKS_SVH

int n_checks = 0;
int n_mismatch = 0;
int n_fail = 0;

task check_inst(input logic [31:0] got, input logic [31:0] exp, input string name);
  n_checks++;
  if (got !== exp) begin
    n_mismatch++;
    $display("MISMATCH %s at %0t ns: got %08h, expected %08h", name, $time, got, exp);
  end
endtask

task check_pc(input fetch_addr_u got, input fetch_addr_u exp, input string name);
  n_checks++;
  if (got.word !== exp.word) begin
    n_mismatch++;
    $display("MISMATCH %s at %0t ns: got %08h, expected %08h", name, $time, got.word, exp.word);
  end
endtask

task check_reads(input int got, input int exp, input fetch_addr_u pc);
  n_checks++;
  if (got != exp) begin
    n_mismatch++;
    $display("MISMATCH mem_arvalid_o reads for pc %08h: got %0h, expected %0h",
             pc.word, got, exp);
  end
endtask

task check_flag(input logic got, input logic exp, input string name);
  n_checks++;
  if (got !== exp) begin
    n_mismatch++;
    $display("MISMATCH %s at %0t ns: got %0h, expected %0h", name, $time, got, exp);
  end
endtask

task report_failure(input string what);
  n_fail++;
  $display("error at %0t ns: %s", $time, what);
endtask

task print_counts;
  $display("%0d checks, %0d mismatches, %0d other failures", n_checks, n_mismatch, n_fail);
endtask

`endif

// File: sim/tb_fetch_top.sv
`timescale 1ns/1ns
`default_nettype none

module tb_fetch_top
  import fetch_pkg::*;
();

  localparam int PROG_WORDS = 64;
  localparam int FENCE_IDX = 21;
  localparam int N_XFER = 600;
  localparam int MAX_LAT = 4;
  // two longest reads per transfer with a factor of three for stalls and back-pressure.
  localparam int WD_CYCLES = N_XFER * MAX_LAT * 2 * 3 + 2000;

  logic        clk;
  logic        rst;
  logic [31:0] inst_o;
  logic [31:0] pc_o;
  logic        valid_o;
  logic        ready_i;
  logic        redirect_i;
  logic [31:0] npc_i;
  logic [31:0] mem_araddr_o;
  logic        mem_arvalid_o;
  logic [31:0] mem_rdata_i;
  logic        mem_rvalid_i;
  logic        cfg_we_i;
  logic [1:0]  cfg_addr_i;
  logic [31:0] cfg_wdata_i;

  integer      seed;
  logic [31:0] mem [PROG_WORDS];
  logic [31:0] rd_q [$];
  logic [1:0]  cfg_addr_q [$];
  logic [31:0] cfg_data_q [$];

  // reference model of pc, stall and cache state.
  fetch_addr_u         m_pc;
  logic                m_stalled;
  logic                m_en;
  logic [31:0]         m_base;
  logic [31:0]         m_limit;
  logic [L1I_SETS-1:0] m_valid;
  logic [TAG_W-1:0]    m_tag [L1I_SETS];
  int                  redir_wait;
  int                  n_redir;
  int                  n_xfer;

  logic        rsp_busy;
  logic        rsp_fire;
  int          rsp_wait;
  logic [31:0] rsp_addr;
  logic        hold_pend;
  logic [31:0] hold_inst;
  logic [31:0] hold_pc;

  `include "tb_fetch_checks.svh"

  fetch_top uut (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  initial begin
    repeat (WD_CYCLES) @(posedge clk);
    $display("watchdog expired after %0d cycles, the fetch unit stopped making progress",
             WD_CYCLES);
    print_counts();
    $display("Errors found");
    $finish;
  end

  // about one random instruction in eight ends sequential fetch.
  task fill_program;
    logic [31:0] r;
    int sel;
    for (int i = 0; i < PROG_WORDS; i++) begin
      r = $random(seed);
      sel = {$random(seed)} % 32;
      case (sel)
        0: r[6:0] = OP_JAL;
        1: r[6:0] = OP_JALR;
        2: r[6:0] = OP_BRANCH;
        3: r[6:0] = OP_SYSTEM;
        default: begin
          case (sel % 4)
            0: r[6:0] = 7'b001_0011;
            1: r[6:0] = 7'b011_0011;
            2: r[6:0] = 7'b000_0011;
            default: r[6:0] = 7'b011_0111;
          endcase
        end
      endcase
      mem[i] = r;
    end
    mem[FENCE_IDX] = INST_FENCE_I;
    r = $random(seed);
    mem[PROG_WORDS-1] = {r[31:7], OP_JAL};
  endtask

  // predict the bus reads of one fetch and update the model cache.
  task predict_fetch(input fetch_addr_u a, output int n, output logic [31:0] r0,
                     output logic [31:0] r1);
    logic cacheable;
    cacheable = m_en && (a.word >= m_base) && (a.word <= m_limit);
    r0 = {a.word[31:3], 3'b000};
    r1 = {a.word[31:3], 3'b100};
    if (cacheable && m_valid[a.f.index] && (m_tag[a.f.index] == a.f.tag)) begin
      n = 0;
    end else if (cacheable) begin
      n = 2;
      m_valid[a.f.index] = 1'b1;
      m_tag[a.f.index] = a.f.tag;
    end else begin
      n = 1;
      r0 = {a.word[31:2], 2'b00};
    end
  endtask

  task sample_bus;
    if (rsp_fire) begin
      rsp_fire = 1'b0;
      rsp_busy = 1'b0;
    end else if (rsp_busy) begin
      if (!mem_arvalid_o || (mem_araddr_o !== rsp_addr)) begin
        report_failure("read request dropped or changed before its response");
      end
    end else if (mem_arvalid_o) begin
      rsp_busy = 1'b1;
      rsp_addr = mem_araddr_o;
      rsp_wait = {$random(seed)} % MAX_LAT;
      rd_q.push_back(mem_araddr_o);
    end
  endtask

  task drive_bus;
    mem_rvalid_i = 1'b0;
    if (rsp_busy && (rsp_wait == 0)) begin
      if (rsp_addr[31:8] != PC_RESET[31:8]) begin
        report_failure($sformatf("read of %08h outside program memory", rsp_addr));
      end
      mem_rvalid_i = 1'b1;
      mem_rdata_i = mem[rsp_addr[7:2]];
      rsp_fire = 1'b1;
    end else if (rsp_busy) begin
      rsp_wait--;
    end
  endtask

  task schedule_cfg_writes;
    case (n_redir)
      12: begin
        cfg_addr_q.push_back(CFG_ADDR_CTRL);
        cfg_data_q.push_back(32'h0);
      end
      // window ends on the even word of a line.
      24: begin
        cfg_addr_q.push_back(CFG_ADDR_CTRL);
        cfg_data_q.push_back(32'h1);
        cfg_addr_q.push_back(CFG_ADDR_BASE);
        cfg_data_q.push_back(32'h8000_0040);
        cfg_addr_q.push_back(CFG_ADDR_LIMIT);
        cfg_data_q.push_back(32'h8000_00A3);
      end
      36: begin
        cfg_addr_q.push_back(CFG_ADDR_BASE);
        cfg_data_q.push_back(CFG_BASE_RESET);
        cfg_addr_q.push_back(CFG_ADDR_LIMIT);
        cfg_data_q.push_back(CFG_LIMIT_RESET);
      end
      default: begin
      end
    endcase
  endtask

  task take_transfer;
    int exp_n;
    logic [31:0] r0;
    logic [31:0] r1;
    logic [31:0] exp_inst;
    exp_inst = mem[m_pc.word[7:2]];
    check_pc(pc_o, m_pc, "pc_o");
    check_inst(inst_o, exp_inst, "inst_o");
    predict_fetch(m_pc, exp_n, r0, r1);
    check_reads(rd_q.size(), exp_n, m_pc);
    if ((exp_n > 0) && (rd_q.size() == exp_n)) begin
      check_pc(rd_q[0], r0, "mem_araddr_o");
      if (exp_n > 1) begin
        check_pc(rd_q[1], r1, "mem_araddr_o");
      end
    end
    rd_q.delete();
    n_xfer++;
    case (exp_inst[6:0])
      OP_JAL, OP_JALR, OP_BRANCH, OP_SYSTEM: begin
        m_stalled = 1'b1;
        redir_wait = {$random(seed)} % 4;
        schedule_cfg_writes();
      end
      default: begin
        if (exp_inst == INST_FENCE_I) begin
          m_valid = '0;
        end
        m_pc.word = m_pc.word + 32'd4;
      end
    endcase
  endtask

  task sample_decode;
    if (m_stalled && valid_o) begin
      report_failure("valid_o high while waiting for a redirect");
    end
    // an offered word must hold until decode takes it.
    if (hold_pend) begin
      check_flag(valid_o, 1'b1, "valid_o");
      check_inst(inst_o, hold_inst, "inst_o");
      check_pc(pc_o, hold_pc, "pc_o");
    end
    hold_pend = valid_o && !ready_i;
    hold_inst = inst_o;
    hold_pc = pc_o;
    if (valid_o && ready_i) begin
      take_transfer();
    end
  endtask

  task drive_decode;
    cfg_we_i = 1'b0;
    redirect_i = 1'b0;
    ready_i = ({$random(seed)} % 4) != 0;
    if (m_stalled && (cfg_addr_q.size() > 0)) begin
      cfg_we_i = 1'b1;
      cfg_addr_i = cfg_addr_q.pop_front();
      cfg_wdata_i = cfg_data_q.pop_front();
      case (cfg_addr_i)
        CFG_ADDR_CTRL: m_en = cfg_wdata_i[0];
        CFG_ADDR_BASE: m_base = cfg_wdata_i;
        default: m_limit = cfg_wdata_i;
      endcase
    end else if (m_stalled && (redir_wait > 0)) begin
      redir_wait--;
    end else if (m_stalled) begin
      n_redir++;
      if (n_redir % 8 == 0) begin
        m_pc.word = PC_RESET + FENCE_IDX * 4;
      end else begin
        m_pc.word = PC_RESET + ({$random(seed)} % PROG_WORDS) * 4;
      end
      redirect_i = 1'b1;
      npc_i = m_pc.word;
      m_stalled = 1'b0;
    end else if (({$random(seed)} % 16) == 0) begin
      // not stalled, so this one must be ignored.
      redirect_i = 1'b1;
      npc_i = PC_RESET + ({$random(seed)} % PROG_WORDS) * 4;
    end
  endtask

  initial begin
    seed = 32'h5e47;
    rst = 1'b1;
    ready_i = 1'b0;
    redirect_i = 1'b0;
    npc_i = 32'h0;
    mem_rdata_i = 32'h0;
    mem_rvalid_i = 1'b0;
    cfg_we_i = 1'b0;
    cfg_addr_i = 2'd0;
    cfg_wdata_i = 32'h0;
    m_pc.word = PC_RESET;
    m_stalled = 1'b0;
    m_en = 1'b1;
    m_base = CFG_BASE_RESET;
    m_limit = CFG_LIMIT_RESET;
    m_valid = '0;
    redir_wait = 0;
    n_redir = 0;
    n_xfer = 0;
    rsp_busy = 1'b0;
    rsp_fire = 1'b0;
    rsp_wait = 0;
    rsp_addr = 32'h0;
    hold_pend = 1'b0;
    fill_program();
    repeat (16) @(posedge clk);
    check_flag(valid_o, 1'b0, "valid_o");
    check_flag(mem_arvalid_o, 1'b0, "mem_arvalid_o");
    check_pc(pc_o, PC_RESET, "pc_o");
    @(negedge clk);
    rst = 1'b0;
    while (n_xfer < N_XFER) begin
      @(posedge clk);
      sample_bus();
      sample_decode();
      @(negedge clk);
      drive_bus();
      drive_decode();
    end
    print_counts();
    if ((n_mismatch + n_fail) == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: fetch_sys.f
+incdir+sim
hw/fetch_pkg.sv
hw/l1i_lookup_if.sv
hw/fetch_cfg_regs.sv
hw/l1i_cache.sv
hw/ifu_pc_ctrl.sv
hw/fetch_top.sv
sim/tb_fetch_top.sv

// File: Makefile
TOP := tb_fetch_top

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f fetch_sys.f

obj_dir/V$(TOP): fetch_sys.f $(wildcard hw/*.sv sim/*.sv sim/*.svh)
	verilator --binary --timing -j 0 --top-module $(TOP) -f fetch_sys.f

sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -qx "No errors" sim.log

clean:
	rm -rf obj_dir sim.log
